// ==== tb.f ====
hw/spi_msg_pkg.sv
hw/msg_receiver.sv
hw/msg_decoder.sv
hw/resp_transmitter.sv
hw/ice_spi_top.sv
tb/tb_ice_spi_top.sv

// ==== Makefile ====
# Verilator build for the quad-SPI command port testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_ice_spi_top
FILELIST  ?= tb.f

OBJ_DIR := obj_dir
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# Output is shown, then searched for the pass line
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/tb_ice_spi_top.sv ====
`timescale 1ns/1ps

module tb_ice_spi_top;

    localparam int dummy_cycles = 2;
    localparam int led_width    = 4;

    // About 45 cycles per transaction, 60 transactions, plus margin
    localparam int txn_cycles = 45;
    localparam int txn_count  = 60;
    localparam int max_cycles = txn_cycles * txn_count + 1300;

    logic                 ice_st_spi_clk = 1'b0;
    logic                 spi_cs;
    logic [3:0]           d_in;
    logic [7:0]           d_out;
    logic                 d_out_en;
    logic [led_width-1:0] led;

    int          errors       = 0;
    int          checks       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          cycle_cnt    = 0;
    int          resp_cnt     = 0;
    logic [31:0] lcg_state    = 32'd9707;
    logic [3:0]  exp_led      = 4'h0;
    logic [63:0] exp_q [$];

    // Compare process state
    int          pair_idx   = 0;
    logic [63:0] pair_bits  = '0;
    logic        resp_done  = 1'b0;
    logic        stray_seen = 1'b0;

    ice_spi_top #(
        .dummy_cycles (dummy_cycles),
        .led_width    (led_width)
    ) dut (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .d_in           (d_in),
        .d_out          (d_out),
        .d_out_en       (d_out_en),
        .led            (led)
    );

    always #2 ice_st_spi_clk = ~ice_st_spi_clk;

    always @(posedge ice_st_spi_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("Run stopped because the cycle limit of %0d was reached", max_cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // ========================================================================
    // Reference model and helpers
    // ========================================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Returns 1 when the message expects a response
    function automatic logic ref_model(input logic [63:0] m, input logic [3:0] led_in,
                                       output logic [63:0] resp, output logic [3:0] led_out);
        logic [7:0] mtype;
        mtype   = {1'b1, m[62:56]};
        resp    = '0;
        led_out = led_in;
        if (mtype == 8'hC0) begin
            resp = {m[55:0], 8'h00};
            return 1'b1;
        end
        if (mtype == 8'h80) begin
            led_out = m[3:0];
        end
        return 1'b0;
    endfunction

    // Pair k sits at bits 63-8k; two pairs per 16-bit word, top word first
    function automatic logic [63:0] reassemble(input logic [63:0] pairs);
        logic [63:0] r;
        logic [7:0]  p;
        int          base;
        r = '0;
        for (int k = 0; k < 8; k++) begin
            p    = pairs[63 - 8*k -: 8];
            base = 48 - 16 * (k / 2);
            if (k % 2 == 0) begin
                r[base+12 +: 4] = p[7:4];
                r[base+4 +: 4]  = p[3:0];
            end else begin
                r[base+8 +: 4] = p[7:4];
                r[base +: 4]   = p[3:0];
            end
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // ========================================================================
    // Compare process
    // ========================================================================

    always @(negedge ice_st_spi_clk) begin
        if (!spi_cs) begin
            pair_idx   = 0;
            resp_done  = 1'b0;
            stray_seen = 1'b0;
        end else if (d_out_en) begin
            if (resp_done) begin
                // Shift register has run dry
                check_value("d_out", 64'(d_out), 64'h0);
            end else if (pair_idx == 0 && exp_q.size() == 0) begin
                if (!stray_seen) begin
                    $display("At %0t d_out_en rose for a message without a response", $time);
                    errors++;
                end
                stray_seen = 1'b1;
            end else begin
                pair_bits[63 - 8*pair_idx -: 8] = d_out;
                pair_idx++;
                if (pair_idx == 8) begin
                    check_value("resp", reassemble(pair_bits), exp_q.pop_front());
                    resp_done = 1'b1;
                    resp_cnt++;
                end
            end
        end
    end

    // ========================================================================
    // Transaction tasks
    // ========================================================================

    task automatic send_nibbles(input logic [63:0] m, input int count);
        @(posedge ice_st_spi_clk);
        spi_cs <= 1'b1;
        d_in   <= 4'h0;
        for (int i = 1; i < dummy_cycles; i++) begin
            @(posedge ice_st_spi_clk);
            d_in <= 4'h0;
        end
        for (int i = 0; i < count; i++) begin
            @(posedge ice_st_spi_clk);
            d_in <= m[63 - 4*i -: 4];
        end
    endtask

    task automatic deselect();
        @(posedge ice_st_spi_clk);
        spi_cs <= 1'b0;
        d_in   <= 4'h0;
        repeat (2) @(posedge ice_st_spi_clk);
    endtask

    task automatic run_txn(input logic [63:0] m);
        logic [63:0] exp_resp;
        logic [3:0]  next_led;
        logic        has_resp;
        int          start_cnt;
        int          waited;
        has_resp  = ref_model(m, exp_led, exp_resp, next_led);
        start_cnt = resp_cnt;
        waited    = 0;
        if (has_resp) begin
            exp_q.push_back(exp_resp);
        end
        send_nibbles(m, 16);
        if (has_resp) begin
            while (resp_cnt == start_cnt && waited < 20) begin
                @(posedge ice_st_spi_clk);
                waited++;
            end
            if (resp_cnt == start_cnt) begin
                $display("At %0t d_out_en never rose or the response was cut short", $time);
                errors++;
                exp_q.delete();
            end
        end else begin
            // Long enough for a stray response to show up
            repeat (14) @(posedge ice_st_spi_clk);
        end
        deselect();
        exp_led = next_led;
        check_value("led", 64'(led), 64'(exp_led));
    endtask

    // Drops chip select partway through the message
    task automatic run_abort(input logic [63:0] m, input int count);
        send_nibbles(m, count);
        repeat (4) @(posedge ice_st_spi_clk);
        deselect();
        check_value("led", 64'(led), 64'(exp_led));
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("[%0t] %s: ok", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: %0d errors", $time, name, errors - err_before);
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        int          err_before;
        logic [55:0] payload;
        spi_cs = 1'b0;
        d_in   = 4'h0;
        repeat (5) @(posedge ice_st_spi_clk);

        err_before = errors;
        run_txn({8'hC0, 56'h0123456789ABCD});
        finish_test("echo fixed payload", err_before);

        err_before = errors;
        run_txn({8'h80, 52'h0, 4'h5});
        run_txn({8'hC0, 56'hFEDCBA98765432});
        finish_test("led set and hold", err_before);

        err_before = errors;
        run_txn({8'h81, 56'hFFFFFFFFFFFFFF});
        run_txn({8'h05, 56'h0000000000000A});
        finish_test("nop and unknown type", err_before);

        err_before = errors;
        run_txn({8'h40, 56'h55AA55AA55AA55});
        finish_test("echo with top type bit cleared", err_before);

        err_before = errors;
        for (int n = 0; n < 50; n++) begin
            lcg_state      = lcg_next(lcg_state);
            payload[55:32] = lcg_state[31:8];
            lcg_state      = lcg_next(lcg_state);
            payload[31:0]  = lcg_state;
            run_txn({8'hC0, payload});
        end
        finish_test("random echo x50", err_before);

        err_before = errors;
        run_abort({8'h80, 52'h0, 4'hA}, 10);
        run_txn({8'hC0, 56'h13579BDF02468A});
        finish_test("aborted transaction", err_before);

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== hw/ice_spi_top.sv ====
`timescale 1ns/1ps

module ice_spi_top #(
    parameter int dummy_cycles = 2,
    parameter int led_width    = 4
) (
    input  logic                 ice_st_spi_clk,
    input  logic                 spi_cs,
    input  logic [3:0]           d_in,
    output logic [7:0]           d_out,
    output logic                 d_out_en,
    output logic [led_width-1:0] led
);
    import spi_msg_pkg::*;

    // Receiver to decoder
    logic [msg_len-1:0]  msg;
    logic                msg_valid;

    // Decoder to transmitter
    logic [resp_len-1:0] resp;
    logic                resp_start;

    // ========================================================================
    // Message receiver
    // ========================================================================

    msg_receiver #(
        .dummy_cycles (dummy_cycles)
    ) u_msg_receiver (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .d_in           (d_in),
        .msg            (msg),
        .msg_valid      (msg_valid)
    );

    // ========================================================================
    // Decoder and LED register
    // ========================================================================

    msg_decoder #(
        .led_width (led_width)
    ) u_msg_decoder (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .msg            (msg),
        .msg_valid      (msg_valid),
        .resp           (resp),
        .resp_start     (resp_start),
        .led            (led)
    );

    // ========================================================================
    // Response transmitter
    // ========================================================================

    resp_transmitter u_resp_transmitter (
        .ice_st_spi_clk (ice_st_spi_clk),
        .spi_cs         (spi_cs),
        .resp           (resp),
        .resp_start     (resp_start),
        .d_out          (d_out),
        .d_out_en       (d_out_en)
    );

endmodule

// ==== hw/resp_transmitter.sv ====
`timescale 1ns/1ps

module resp_transmitter (
    input  logic                             ice_st_spi_clk,
    input  logic                             spi_cs,
    input  logic [spi_msg_pkg::resp_len-1:0] resp,
    input  logic                             resp_start,
    output logic [7:0]                       d_out,
    output logic                             d_out_en
);
    import spi_msg_pkg::*;

    // ========================================================================
    // Output shift registers
    // ========================================================================

    // Current 16-bit word and the words still waiting behind it
    logic [15:0]         word_sr;
    logic [resp_len-1:0] resp_sr;

    // High when the second pair of the current word is on the bus
    logic                second_half;

    // Two nibbles of the current word per clock
    //   high nibble from word bits 15:12, low nibble from bits 7:4
    assign d_out = {word_sr[15:12], word_sr[7:4]};

    always_ff @(posedge ice_st_spi_clk) begin
        if (resp_start) begin
            // Word 63:48 goes out first
            word_sr <= resp[resp_len-1 -: 16];
            resp_sr <= {resp[resp_len-17:0], 16'h0000};
        end else if (d_out_en) begin
            if (!second_half) begin
                // Move bits 11:8 and 3:0 up into the output slots
                word_sr <= word_sr << 4;
            end else begin
                // Next word, zeros once the response runs out
                word_sr <= resp_sr[resp_len-1 -: 16];
                resp_sr <= resp_sr << 16;
            end
        end
    end

    // ========================================================================
    // Control
    // ========================================================================

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            d_out_en    <= 1'b0;
            second_half <= 1'b0;
        end else if (resp_start) begin
            d_out_en    <= 1'b1;
            second_half <= 1'b0;
        end else if (d_out_en) begin
            second_half <= !second_half;
        end
    end

endmodule

// ==== hw/msg_decoder.sv ====
`timescale 1ns/1ps

module msg_decoder #(
    parameter int led_width = 4
) (
    input  logic                             ice_st_spi_clk,
    input  logic                             spi_cs,
    input  logic [spi_msg_pkg::msg_len-1:0]  msg,
    input  logic                             msg_valid,
    output logic [spi_msg_pkg::resp_len-1:0] resp,
    output logic                             resp_start,
    output logic [led_width-1:0]             led
);
    import spi_msg_pkg::*;

    // ========================================================================
    // Field extraction
    // ========================================================================

    logic [msg_type_len-1:0] msg_type;
    msg_arg_t                msg_arg;
    logic                    resp_expected;
    logic                    is_echo;
    logic                    is_led_set;

    // The controller cannot set the top bit, so it is faked here
    assign msg_type = {1'b1, msg[msg_len-2 -: msg_type_len-1]};
    assign msg_arg  = msg[msg_arg_len-1:0];

    // Response flag carried in the type code itself
    assign resp_expected = msg_type[msg_type_resp_bit];

    // ========================================================================
    // Type decode
    // ========================================================================

    always_comb begin
        is_echo    = 1'b0;
        is_led_set = 1'b0;
        case (msg_type)
            msg_type_echo: begin
                is_echo = 1'b1;
            end
            msg_type_led_set: begin
                is_led_set = 1'b1;
            end
            msg_type_nop: begin
                // Nothing to do
            end
            default: begin
                // Unknown codes fall through like Nop
            end
        endcase
    end

    // ========================================================================
    // Response build
    // ========================================================================

    // Echo payload goes back in the upper bits, low byte zero
    always_ff @(posedge ice_st_spi_clk) begin
        if (msg_valid && is_echo) begin
            resp <= {msg_arg.echo_payload, {(resp_len - msg_arg_len){1'b0}}};
        end
    end

    // One pulse per answered message
    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            resp_start <= 1'b0;
        end else begin
            resp_start <= msg_valid && is_echo && resp_expected;
        end
    end

    // ========================================================================
    // LED register
    // ========================================================================

    // Survives deselect, so the LEDs keep their state between transactions
    logic [led_width-1:0] led_q = '0;

    always_ff @(posedge ice_st_spi_clk) begin
        if (msg_valid && is_led_set) begin
            led_q <= led_width'(msg_arg.led.led_val);
        end
    end

    assign led = led_q;

endmodule

// ==== hw/msg_receiver.sv ====
`timescale 1ns/1ps

module msg_receiver #(
    parameter int dummy_cycles = 2
) (
    input  logic                            ice_st_spi_clk,
    input  logic                            spi_cs,
    input  logic [3:0]                      d_in,
    output logic [spi_msg_pkg::msg_len-1:0] msg,
    output logic                            msg_valid
);
    import spi_msg_pkg::*;

    // ========================================================================
    // Cycle counter
    // ========================================================================

    // Messages come in on four lines, one nibble per clock
    localparam int msg_cycles   = msg_len / 4;
    localparam int total_cycles = dummy_cycles + msg_cycles;
    localparam int cnt_w        = $clog2(total_cycles + 1);

    // First message nibble, last message nibble and the parked value
    localparam logic [cnt_w-1:0] first_msg_cnt = cnt_w'(dummy_cycles);
    localparam logic [cnt_w-1:0] last_msg_cnt  = cnt_w'(total_cycles - 1);
    localparam logic [cnt_w-1:0] done_cnt      = cnt_w'(total_cycles);

    logic [cnt_w-1:0] cycle_cnt;
    logic             parked;
    logic             shift_en;

    // Counter stops once the whole message is in
    assign parked = (cycle_cnt == done_cnt);

    // Dummy nibbles are sampled but never shifted
    assign shift_en = spi_cs && !parked && (cycle_cnt >= first_msg_cnt);

    always_ff @(posedge ice_st_spi_clk or negedge spi_cs) begin
        if (!spi_cs) begin
            cycle_cnt <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            if (!parked) begin
                cycle_cnt <= cycle_cnt + 1'b1;
                // Last nibble lands on this edge
                if (cycle_cnt == last_msg_cnt) begin
                    msg_valid <= 1'b1;
                end
            end
        end
    end

    // ========================================================================
    // Nibble shift register
    // ========================================================================

    // MSB nibble first, so older nibbles move up
    // Holds still after the counter parks until chip select drops
    always_ff @(posedge ice_st_spi_clk) begin
        if (shift_en) begin
            msg <= {msg[msg_len-5:0], d_in};
        end
    end

endmodule

// ==== hw/spi_msg_pkg.sv ====
package spi_msg_pkg;

    // ========================================================================
    // Message layout
    // ========================================================================

    // Type field sits in the top byte of the message
    localparam int msg_type_len = 8;

    // Argument fills the rest of the message
    localparam int msg_arg_len = 56;

    // Full message shifted in from the controller
    localparam int msg_len = msg_type_len + msg_arg_len;

    // Response word sent back on the eight data lines
    localparam int resp_len = 64;

    // Type bit that says a response follows
    localparam int msg_type_resp_bit = 6;

    // LED value width inside the argument
    localparam int led_val_len = 4;

    // ========================================================================
    // Type codes
    // ========================================================================

    // Bit 7 is always forced high by the decoder
    // Bit 6 set means the controller clocks out a response

    // Echo returns its payload
    localparam logic [msg_type_len-1:0] msg_type_echo = 8'hC0;

    // LED set loads the LED register, no response
    localparam logic [msg_type_len-1:0] msg_type_led_set = 8'h80;

    // Nop does nothing
    localparam logic [msg_type_len-1:0] msg_type_nop = 8'h81;

    // ========================================================================
    // Argument views
    // ========================================================================

    // Same 56-bit argument word, read per message type
    typedef union packed {
        // Echo carries the whole argument back
        logic [msg_arg_len-1:0] echo_payload;
        // LED set only looks at the lowest bits
        struct packed {
            logic [msg_arg_len-led_val_len-1:0] unused;
            logic [led_val_len-1:0]             led_val;
        } led;
    } msg_arg_t;

endpackage
